// File: csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// register addresses
`define CSR_CRMD      14'h0
`define CSR_PRMD      14'h1
`define CSR_ECTL      14'h4
`define CSR_ESTAT     14'h5
`define CSR_ERA       14'h6
`define CSR_EENTRY    14'hc
`define CSR_SAVE0     14'h30
`define CSR_SAVE1     14'h31
`define CSR_SAVE2     14'h32
`define CSR_SAVE3     14'h33
`define CSR_TID       14'h40
`define CSR_TCFG      14'h41
`define CSR_TVAL      14'h42
`define CSR_TICLR     14'h44

// crmd fields
`define PLV           1:0
`define IE            2
`define DA            3
`define PG            4
`define DATF          6:5
`define DATM          8:7

// prmd fields
`define PPLV          1:0
`define PIE           2

// ectl, bit 10 not implemented
`define LIE           12:0
`define LIE_HI        12:11
`define LIE_LO        9:0

// estat fields
`define IS            12:0
`define ECODE         21:16
`define ESUBCODE      30:22
`define TIMER_IS      11

// timer fields
`define TCFG_EN       0
`define TCFG_PERIODIC 1
`define TCFG_INITVAL  31:2
`define TICLR_CLR     0

`endif

// File: csr_pkg.sv
package csr_pkg;

    // register address
    typedef logic [13:0] csr_addr_t;

    // register value or write data
    typedef logic [31:0] csr_word_t;

    // privilege level
    typedef logic [1:0]  plv_t;

    // exception code and subcode
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // hardware interrupt lines
    typedef logic [7:0]  hw_int_t;

endpackage

// File: csr_trap_if.sv
`timescale 1ns/1ps

interface csr_trap_if;
    import csr_pkg::*;

    // one-cycle pulses, excp_flush has priority
    logic      excp_flush;
    logic      ertn_flush;
    csr_word_t era;
    ecode_t    ecode;
    esubcode_t esubcode;

    modport src (
        output excp_flush, ertn_flush, era, ecode, esubcode
    );

    modport dst (
        input  excp_flush, ertn_flush, era, ecode, esubcode
    );

endinterface

// File: csr_trap_regs.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_trap_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic                csr_wr_en,
    input  csr_pkg::csr_addr_t  wr_addr,
    input  csr_pkg::csr_word_t  wr_data,
    csr_trap_if.dst             trap,
    input  csr_pkg::hw_int_t    interrupt,
    input  logic                timer_fire,
    output logic                has_int,
    output csr_pkg::plv_t       plv_out,
    output csr_pkg::csr_word_t  crmd,
    output csr_pkg::csr_word_t  prmd,
    output csr_pkg::csr_word_t  ectl,
    output csr_pkg::csr_word_t  estat,
    output csr_pkg::csr_word_t  era,
    output csr_pkg::csr_word_t  eentry
);

    logic crmd_wen;
    logic prmd_wen;
    logic ectl_wen;
    logic estat_wen;
    logic era_wen;
    logic eentry_wen;
    logic ticlr_wen;

    assign crmd_wen   = csr_wr_en && (wr_addr == `CSR_CRMD);
    assign prmd_wen   = csr_wr_en && (wr_addr == `CSR_PRMD);
    assign ectl_wen   = csr_wr_en && (wr_addr == `CSR_ECTL);
    assign estat_wen  = csr_wr_en && (wr_addr == `CSR_ESTAT);
    assign era_wen    = csr_wr_en && (wr_addr == `CSR_ERA);
    assign eentry_wen = csr_wr_en && (wr_addr == `CSR_EENTRY);
    assign ticlr_wen  = csr_wr_en && (wr_addr == `CSR_TICLR);

    // crmd, da comes out of reset set
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= 32'h8;
        end else if (trap.excp_flush) begin
            crmd[`PLV] <= 2'b0;
            crmd[`IE]  <= 1'b0;
        end else if (trap.ertn_flush) begin
            crmd[`PLV] <= prmd[`PPLV];
            crmd[`IE]  <= prmd[`PIE];
        end else if (crmd_wen) begin
            crmd[`PLV]  <= wr_data[`PLV];
            crmd[`IE]   <= wr_data[`IE];
            crmd[`DA]   <= wr_data[`DA];
            crmd[`PG]   <= wr_data[`PG];
            crmd[`DATF] <= wr_data[`DATF];
            crmd[`DATM] <= wr_data[`DATM];
        end
    end

    // prmd saves plv/ie on entry
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= '0;
        end else if (trap.excp_flush) begin
            prmd[`PPLV] <= crmd[`PLV];
            prmd[`PIE]  <= crmd[`IE];
        end else if (prmd_wen) begin
            prmd[`PPLV] <= wr_data[`PPLV];
            prmd[`PIE]  <= wr_data[`PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ectl <= '0;
        end else if (ectl_wen) begin
            ectl[`LIE_HI] <= wr_data[`LIE_HI];
            ectl[`LIE_LO] <= wr_data[`LIE_LO];
        end
    end

    // estat: sw bits, sampled hw lines, timer bit, codes
    always_ff @(posedge clk) begin
        if (reset) begin
            estat <= '0;
        end else begin
            estat[9:2] <= interrupt;
            // clear beats a fire in the same cycle
            if (ticlr_wen && wr_data[`TICLR_CLR]) begin
                estat[`TIMER_IS] <= 1'b0;
            end else if (timer_fire) begin
                estat[`TIMER_IS] <= 1'b1;
            end
            if (trap.excp_flush) begin
                estat[`ECODE]    <= trap.ecode;
                estat[`ESUBCODE] <= trap.esubcode;
            end else if (estat_wen) begin
                estat[1:0] <= wr_data[1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trap.excp_flush) begin
            era <= trap.era;
        end else if (era_wen) begin
            era <= wr_data;
        end
    end

    // entry point is 64-byte aligned
    always_ff @(posedge clk) begin
        if (reset) begin
            eentry <= '0;
        end else if (eentry_wen) begin
            eentry[31:6] <= wr_data[31:6];
        end
    end

    assign has_int = (|(ectl[`LIE] & estat[`IS])) && crmd[`IE];

    // forwarded privilege level for the fetch side
    always_comb begin
        if (trap.excp_flush) begin
            plv_out = 2'b0;
        end else if (trap.ertn_flush) begin
            plv_out = prmd[`PPLV];
        end else if (crmd_wen) begin
            plv_out = wr_data[`PLV];
        end else begin
            plv_out = crmd[`PLV];
        end
    end

endmodule

// File: csr_timer.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_timer (
    input  logic                clk,
    input  logic                reset,
    input  logic                csr_wr_en,
    input  csr_pkg::csr_addr_t  wr_addr,
    input  csr_pkg::csr_word_t  wr_data,
    output logic                timer_fire,
    output csr_pkg::csr_word_t  tid,
    output csr_pkg::csr_word_t  tcfg,
    output csr_pkg::csr_word_t  tval
);
    import csr_pkg::*;

    logic      tid_wen;
    logic      tcfg_wen;
    logic      timer_en;
    csr_word_t reload_val;

    assign tid_wen    = csr_wr_en && (wr_addr == `CSR_TID);
    assign tcfg_wen   = csr_wr_en && (wr_addr == `CSR_TCFG);
    assign reload_val = {tcfg[`TCFG_INITVAL], 2'b0};

    // a tcfg write restarts the count, so no fire that cycle
    assign timer_fire = timer_en && (tval == '0) && !tcfg_wen;

    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= '0;
        end else if (tid_wen) begin
            tid <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg <= '0;
        end else if (tcfg_wen) begin
            tcfg <= wr_data;
        end
    end

    // one-shot mode stops after the first fire
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_en <= 1'b0;
        end else if (tcfg_wen) begin
            timer_en <= wr_data[`TCFG_EN];
        end else if (timer_fire && !tcfg[`TCFG_PERIODIC]) begin
            timer_en <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_wen) begin
            tval <= {wr_data[`TCFG_INITVAL], 2'b0};
        end else if (timer_fire) begin
            tval <= tcfg[`TCFG_PERIODIC] ? reload_val : '1;
        end else if (timer_en) begin
            tval <= tval - 32'd1;
        end
    end

endmodule

// File: csr_scratch_regs.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_scratch_regs (
    input  logic                clk,
    input  logic                csr_wr_en,
    input  csr_pkg::csr_addr_t  wr_addr,
    input  csr_pkg::csr_word_t  wr_data,
    output csr_pkg::csr_word_t  save0,
    output csr_pkg::csr_word_t  save1,
    output csr_pkg::csr_word_t  save2,
    output csr_pkg::csr_word_t  save3
);
    import csr_pkg::*;

    logic [3:0] save_wen;
    csr_word_t  save_q [0:3];

    assign save_wen[0] = csr_wr_en && (wr_addr == `CSR_SAVE0);
    assign save_wen[1] = csr_wr_en && (wr_addr == `CSR_SAVE1);
    assign save_wen[2] = csr_wr_en && (wr_addr == `CSR_SAVE2);
    assign save_wen[3] = csr_wr_en && (wr_addr == `CSR_SAVE3);

    // software owned, no reset value
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (save_wen[i]) begin
                save_q[i] <= wr_data;
            end
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

// File: csr_read_mux.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_read_mux (
    input  csr_pkg::csr_addr_t  rd_addr,
    input  csr_pkg::csr_word_t  crmd,
    input  csr_pkg::csr_word_t  prmd,
    input  csr_pkg::csr_word_t  ectl,
    input  csr_pkg::csr_word_t  estat,
    input  csr_pkg::csr_word_t  era,
    input  csr_pkg::csr_word_t  eentry,
    input  csr_pkg::csr_word_t  tid,
    input  csr_pkg::csr_word_t  tcfg,
    input  csr_pkg::csr_word_t  tval,
    input  csr_pkg::csr_word_t  save0,
    input  csr_pkg::csr_word_t  save1,
    input  csr_pkg::csr_word_t  save2,
    input  csr_pkg::csr_word_t  save3,
    output csr_pkg::csr_word_t  rd_data
);

    // and-or select, ticlr and unmapped fall through to zero
    assign rd_data = {32{rd_addr == `CSR_CRMD}}   & crmd   |
                     {32{rd_addr == `CSR_PRMD}}   & prmd   |
                     {32{rd_addr == `CSR_ECTL}}   & ectl   |
                     {32{rd_addr == `CSR_ESTAT}}  & estat  |
                     {32{rd_addr == `CSR_ERA}}    & era    |
                     {32{rd_addr == `CSR_EENTRY}} & eentry |
                     {32{rd_addr == `CSR_TID}}    & tid    |
                     {32{rd_addr == `CSR_TCFG}}   & tcfg   |
                     {32{rd_addr == `CSR_TVAL}}   & tval   |
                     {32{rd_addr == `CSR_SAVE0}}  & save0  |
                     {32{rd_addr == `CSR_SAVE1}}  & save1  |
                     {32{rd_addr == `CSR_SAVE2}}  & save2  |
                     {32{rd_addr == `CSR_SAVE3}}  & save3;

endmodule

// File: csr_top.sv
`timescale 1ns/1ps

module csr_top (
    input  logic                   clk,
    input  logic                   reset,
    input  csr_pkg::csr_addr_t     rd_addr,
    output csr_pkg::csr_word_t     rd_data,
    input  logic                   csr_wr_en,
    input  csr_pkg::csr_addr_t     wr_addr,
    input  csr_pkg::csr_word_t     wr_data,
    input  csr_pkg::hw_int_t       interrupt,
    input  logic                   excp_flush,
    input  logic                   ertn_flush,
    input  csr_pkg::csr_word_t     era_in,
    input  csr_pkg::ecode_t        ecode_in,
    input  csr_pkg::esubcode_t     esubcode_in,
    output logic                   has_int,
    output csr_pkg::plv_t          plv_out,
    output csr_pkg::csr_word_t     era_out,
    output csr_pkg::csr_word_t     eentry_out,
    output csr_pkg::csr_word_t     tid_out
);
    import csr_pkg::*;

    csr_word_t crmd;
    csr_word_t prmd;
    csr_word_t ectl;
    csr_word_t estat;
    csr_word_t tcfg;
    csr_word_t tval;
    csr_word_t save0;
    csr_word_t save1;
    csr_word_t save2;
    csr_word_t save3;
    logic      timer_fire;

    // trap bundle, driven from the pipeline side ports
    csr_trap_if trap ();

    assign trap.excp_flush = excp_flush;
    assign trap.ertn_flush = ertn_flush;
    assign trap.era        = era_in;
    assign trap.ecode      = ecode_in;
    assign trap.esubcode   = esubcode_in;

    csr_trap_regs u_trap_regs (
        .clk        (clk),
        .reset      (reset),
        .csr_wr_en  (csr_wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .trap       (trap),
        .interrupt  (interrupt),
        .timer_fire (timer_fire),
        .has_int    (has_int),
        .plv_out    (plv_out),
        .crmd       (crmd),
        .prmd       (prmd),
        .ectl       (ectl),
        .estat      (estat),
        .era        (era_out),
        .eentry     (eentry_out)
    );

    csr_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_wr_en  (csr_wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .timer_fire (timer_fire),
        .tid        (tid_out),
        .tcfg       (tcfg),
        .tval       (tval)
    );

    csr_scratch_regs u_scratch_regs (
        .clk        (clk),
        .csr_wr_en  (csr_wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .save0      (save0),
        .save1      (save1),
        .save2      (save2),
        .save3      (save3)
    );

    csr_read_mux u_read_mux (
        .rd_addr    (rd_addr),
        .crmd       (crmd),
        .prmd       (prmd),
        .ectl       (ectl),
        .estat      (estat),
        .era        (era_out),
        .eentry     (eentry_out),
        .tid        (tid_out),
        .tcfg       (tcfg),
        .tval       (tval),
        .save0      (save0),
        .save1      (save1),
        .save2      (save2),
        .save3      (save3),
        .rd_data    (rd_data)
    );

endmodule

// File: csr_props.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_props (
    input  logic                clk,
    input  logic                reset,
    input  logic                excp_flush,
    input  logic                csr_wr_en,
    input  csr_pkg::csr_addr_t  wr_addr,
    input  csr_pkg::csr_word_t  wr_data,
    input  logic                has_int,
    input  csr_pkg::plv_t       plv_out,
    input  csr_pkg::csr_word_t  crmd
);

    int   fail_count = 0;
    logic lie_written;

    // set by the first ectl write that enables a line
    always_ff @(posedge clk) begin
        if (reset) begin
            lie_written <= 1'b0;
        end else if (csr_wr_en && (wr_addr == `CSR_ECTL)
                     && (wr_data[`LIE_HI] != '0 || wr_data[`LIE_LO] != '0)) begin
            lie_written <= 1'b1;
        end
    end

    // request only with the global enable set
    a_int_needs_ie: assert property (@(posedge clk) disable iff (reset)
        has_int |-> crmd[`IE])
        else begin
            $error("has_int high while crmd.ie is clear");
            fail_count++;
        end

    a_plv_on_entry: assert property (@(posedge clk) disable iff (reset)
        excp_flush |-> (plv_out == 2'b0))
        else begin
            $error("plv_out not 0 during excp_flush");
            fail_count++;
        end

    // quiet from reset until software enables a line
    a_quiet_until_enabled: assert property (@(posedge clk) disable iff (reset)
        !lie_written |-> !has_int)
        else begin
            $error("has_int high before any interrupt was enabled in ectl");
            fail_count++;
        end

endmodule

bind csr_top csr_props u_csr_props (
    .clk        (clk),
    .reset      (reset),
    .excp_flush (excp_flush),
    .csr_wr_en  (csr_wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .has_int    (has_int),
    .plv_out    (plv_out),
    .crmd       (crmd)
);

// File: tb_csr_top.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module tb_csr_top;
    import csr_pkg::*;

    localparam int MAX_CYCLES = 20000;
    localparam csr_addr_t MAPPED [14] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ECTL, `CSR_ESTAT,
        `CSR_ERA, `CSR_EENTRY, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
        `CSR_TID, `CSR_TCFG, `CSR_TVAL, `CSR_TICLR};

    logic      clk = 1'b0;
    logic      reset;
    logic      csr_wr_en;
    logic      excp_flush;
    logic      ertn_flush;
    logic      has_int;
    csr_addr_t rd_addr;
    csr_addr_t wr_addr;
    csr_word_t rd_data;
    csr_word_t wr_data;
    csr_word_t era_in;
    csr_word_t era_out;
    csr_word_t eentry_out;
    csr_word_t tid_out;
    hw_int_t   interrupt;
    ecode_t    ecode_in;
    esubcode_t esubcode_in;
    plv_t      plv_out;

    // reference model indexed by address
    csr_word_t m_reg [0:16383];
    logic      m_known [0:16383];
    logic      m_ten;
    int        cycle_count = 0;
    int        checks = 0;
    int        errors = 0;
    int        tests = 0;
    int        test_checks = 0;
    int        test_errors = 0;

    csr_top u_csr_top (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic is_mapped(input csr_addr_t a);
        foreach (MAPPED[k]) begin
            if (MAPPED[k] == a)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic csr_word_t wmask(input csr_addr_t a);
        case (a)
            `CSR_CRMD:   return 32'h1ff;
            `CSR_PRMD:   return 32'h7;
            `CSR_ECTL:   return 32'h1bff;
            `CSR_ESTAT:  return 32'h3;
            `CSR_EENTRY: return 32'hffff_ffc0;
            `CSR_ERA, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TID, `CSR_TCFG:
                return 32'hffff_ffff;
            default:     return 32'h0;
        endcase
    endfunction

    function automatic csr_word_t model_read(input csr_addr_t a);
        if (!is_mapped(a) || a == `CSR_TICLR)
            return '0;
        return m_reg[a];
    endfunction

    function automatic logic exp_has_int();
        return (|(m_reg[`CSR_ECTL][`LIE] & m_reg[`CSR_ESTAT][`IS])) && m_reg[`CSR_CRMD][`IE];
    endfunction

    // mostly kept registers, now and then an unmapped address
    function automatic csr_addr_t pick_addr();
        csr_addr_t a;
        if ($urandom_range(7) != 0)
            return MAPPED[$urandom_range(13)];
        a = csr_addr_t'($urandom);
        while (is_mapped(a))
            a = csr_addr_t'($urandom);
        return a;
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic peek(input csr_addr_t a, output csr_word_t d);
        rd_addr = a;
        #1;
        d = rd_data;
    endtask

    task automatic read_check(input csr_addr_t a, input string what);
        csr_word_t d;
        peek(a, d);
        if (m_known[a])
            check_val($sformatf("%s at %h", what, a), d, model_read(a));
    endtask

    // dedicated era, eentry and tid output ports
    task automatic check_side_outputs();
        if (m_known[`CSR_ERA])
            check_val("era_out", era_out, m_reg[`CSR_ERA]);
        check_val("eentry_out", eentry_out, m_reg[`CSR_EENTRY]);
        check_val("tid_out", tid_out, m_reg[`CSR_TID]);
    endtask

    task automatic write_reg(input csr_addr_t a, input csr_word_t d);
        csr_wr_en = 1'b1;
        wr_addr = a;
        wr_data = d;
    endtask

    task automatic init_model();
        foreach (m_reg[i]) begin
            m_reg[i] = '0;
            m_known[i] = 1'b1;
        end
        m_reg[`CSR_CRMD] = 32'h8;
        m_known[`CSR_ERA] = 1'b0;
        m_known[`CSR_TVAL] = 1'b0;
        for (int k = 0; k < 4; k++)
            m_known[`CSR_SAVE0 + k] = 1'b0;
        m_ten = 1'b0;
    endtask

    // next state from the inputs driven in this cycle
    task automatic update_model();
        logic      fire;
        csr_word_t old_crmd;
        csr_word_t old_prmd;
        csr_word_t old_estat;
        fire = m_ten && (m_reg[`CSR_TVAL] == '0) && !(csr_wr_en && wr_addr == `CSR_TCFG);
        old_crmd = m_reg[`CSR_CRMD];
        old_prmd = m_reg[`CSR_PRMD];
        old_estat = m_reg[`CSR_ESTAT];
        if (csr_wr_en && wmask(wr_addr) != '0) begin
            m_reg[wr_addr] = (m_reg[wr_addr] & ~wmask(wr_addr)) | (wr_data & wmask(wr_addr));
            m_known[wr_addr] = 1'b1;
        end
        if (excp_flush) begin
            m_reg[`CSR_CRMD] = old_crmd & ~32'h7;
            m_reg[`CSR_PRMD] = (old_prmd & ~32'h7) | (old_crmd & 32'h7);
            m_reg[`CSR_ERA] = era_in;
            m_known[`CSR_ERA] = 1'b1;
            m_reg[`CSR_ESTAT] = old_estat;
            m_reg[`CSR_ESTAT][30:16] = {esubcode_in, ecode_in};
        end else if (ertn_flush) begin
            m_reg[`CSR_CRMD] = (old_crmd & ~32'h7) | (old_prmd & 32'h7);
        end
        m_reg[`CSR_ESTAT][9:2] = interrupt;
        if (csr_wr_en && wr_addr == `CSR_TICLR && wr_data[0])
            m_reg[`CSR_ESTAT][11] = 1'b0;
        else if (fire)
            m_reg[`CSR_ESTAT][11] = 1'b1;
        if (csr_wr_en && wr_addr == `CSR_TCFG) begin
            m_reg[`CSR_TVAL] = wr_data & ~32'h3;
            m_known[`CSR_TVAL] = 1'b1;
            m_ten = wr_data[0];
        end else if (fire) begin
            m_ten = m_reg[`CSR_TCFG][1];
            m_reg[`CSR_TVAL] = m_ten ? (m_reg[`CSR_TCFG] & ~32'h3) : '1;
        end else if (m_ten) begin
            m_reg[`CSR_TVAL] = m_reg[`CSR_TVAL] - 32'd1;
        end
    endtask

    task automatic tick();
        update_model();
        @(posedge clk);
        #1;
        csr_wr_en = 1'b0;
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
    endtask

    task automatic wait_timer(output int n);
        csr_word_t d;
        n = 0;
        peek(`CSR_ESTAT, d);
        while (!d[`TIMER_IS] && n < 200) begin
            tick();
            n++;
            peek(`CSR_ESTAT, d);
        end
        if (!d[`TIMER_IS]) begin
            errors++;
            test_errors++;
            $display("timer interrupt bit was never set within 200 cycles");
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-18s %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        int         n;
        int         iv;
        csr_addr_t  a;
        csr_word_t  d;
        logic [2:0] old_pie;
        n = $urandom(30291);
        reset = 1'b1;
        rd_addr = '0;
        csr_wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        interrupt = '0;
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
        era_in = '0;
        ecode_in = '0;
        esubcode_in = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        init_model();

        check_val("plv_out after reset", 32'(plv_out), 32'h0);
        check_val("has_int after reset", 32'(has_int), 32'h0);
        foreach (MAPPED[k]) begin
            read_check(MAPPED[k], "reset value");
            tick();
        end
        for (int i = 0; i < 300; i++) begin
            a = pick_addr();
            write_reg(a, $urandom);
            tick();
            read_check(a, "read-back");
            check_side_outputs();
        end
        end_test("write/read");

        for (int i = 0; i < 20; i++) begin
            write_reg(`CSR_CRMD, $urandom);
            tick();
            old_pie = m_reg[`CSR_CRMD][2:0];
            excp_flush = 1'b1;
            era_in = $urandom;
            ecode_in = ecode_t'($urandom);
            esubcode_in = esubcode_t'($urandom);
            #1;
            check_val("plv_out in entry cycle", 32'(plv_out), 32'h0);
            tick();
            peek(`CSR_CRMD, d);
            check_val("crmd plv/ie after entry", 32'(d[2:0]), 32'h0);
            peek(`CSR_PRMD, d);
            check_val("prmd after entry", d, 32'(old_pie));
            peek(`CSR_ERA, d);
            check_val("era after entry", d, era_in);
            peek(`CSR_ESTAT, d);
            check_val("estat codes after entry", 32'(d[30:16]), 32'({esubcode_in, ecode_in}));
            check_side_outputs();
        end
        end_test("exception entry");

        for (int i = 0; i < 20; i++) begin
            write_reg(`CSR_PRMD, $urandom);
            tick();
            write_reg(`CSR_CRMD, $urandom);
            tick();
            ertn_flush = 1'b1;
            if ($urandom_range(1) == 1)
                write_reg(`CSR_CRMD, $urandom);
            #1;
            check_val("plv_out in return cycle", 32'(plv_out), 32'(m_reg[`CSR_PRMD][1:0]));
            tick();
            peek(`CSR_CRMD, d);
            check_val("crmd plv/ie after return", 32'(d[2:0]), 32'(m_reg[`CSR_PRMD][2:0]));
            read_check(`CSR_CRMD, "crmd after return");
        end
        // entry and return together, entry wins
        // prmd and crmd differ so the winner shows
        write_reg(`CSR_PRMD, 32'h3);
        tick();
        write_reg(`CSR_CRMD, ($urandom & ~32'h7) | 32'h4);
        tick();
        old_pie = m_reg[`CSR_CRMD][2:0];
        excp_flush = 1'b1;
        ertn_flush = 1'b1;
        #1;
        check_val("plv_out with both flushes", 32'(plv_out), 32'h0);
        tick();
        peek(`CSR_CRMD, d);
        check_val("crmd plv/ie with both flushes", 32'(d[2:0]), 32'h0);
        peek(`CSR_PRMD, d);
        check_val("prmd with both flushes", d, 32'(old_pie));
        end_test("exception return");

        for (int mode = 0; mode < 2; mode++) begin
            repeat (3) begin
                iv = $urandom_range(15, 1);
                write_reg(`CSR_TICLR, 32'h1);
                tick();
                write_reg(`CSR_TCFG, {30'(iv), 1'(mode), 1'b1});
                tick();
                wait_timer(n);
                check_val("cycles from tcfg write to timer bit", n, 4 * iv + 1);
                if (mode == 0) begin
                    peek(`CSR_TVAL, d);
                    check_val("tval after one-shot", d, 32'hffff_ffff);
                end else begin
                    write_reg(`CSR_TICLR, 32'h1);
                    tick();
                    peek(`CSR_ESTAT, d);
                    check_val("timer bit after ticlr", 32'(d[`TIMER_IS]), 32'h0);
                    wait_timer(n);
                    check_val("cycles to periodic refire", n, 4 * iv);
                end
                write_reg(`CSR_TCFG, 32'h0);
                tick();
                write_reg(`CSR_TICLR, 32'h1);
                tick();
                read_check(`CSR_ESTAT, "estat after timer stop");
            end
        end
        end_test("timer");

        for (int i = 0; i < 60; i++) begin
            interrupt = hw_int_t'($urandom);
            case ($urandom_range(2))
                0: write_reg(`CSR_ECTL, $urandom);
                1: write_reg(`CSR_ESTAT, $urandom);
                default: write_reg(`CSR_CRMD, $urandom);
            endcase
            tick();
            peek(`CSR_ESTAT, d);
            check_val("estat hw lines", 32'(d[9:2]), 32'(interrupt));
            read_check(`CSR_ESTAT, "estat");
            check_val("has_int", 32'(has_int), 32'(exp_has_int()));
        end
        end_test("interrupt request");

        n = u_csr_top.u_csr_props.fail_count;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
            tests, checks, errors, n);
        if (errors == 0 && n == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
csr_pkg.sv
csr_trap_if.sv
csr_trap_regs.sv
csr_timer.sv
csr_scratch_regs.sv
csr_read_mux.sv
csr_top.sv
csr_props.sv
tb_csr_top.sv
